// ==== ddr2_cmd_front.f ====
+incdir+design
design/ddr2_pkg.sv
design/ddr2_init_rom.sv
design/ddr2_wait_timer.sv
design/ddr2_init_seq.sv
design/ddr2_bank_tracker.sv
design/ddr2_cmd_front.sv
verification/ddr2_cmd_front_props.sv
verification/ddr2_cmd_front_tb.sv

// ==== design/ddr2_bank_tracker.sv ====
`timescale 1ns/1ps
`include "ddr2_macros.svh"

module ddr2_bank_tracker import ddr2_pkg::*; (
	input  logic                         CLK_n,
	input  logic                         RST,
	input  logic                         cke,
	input  ddr2_cmd_e                    cmd_pin,
	input  ddr2_addr_u                   addr_pin,
	input  logic [`DDR2_BANK_W-1:0]      bank_pin,
	output logic [(1<<`DDR2_BANK_W)-1:0] bank_open,
	output logic                         protocol_error
);

	logic hit_open; // addressed bank already open
	logic any_open;

	assign hit_open = bank_open[bank_pin];
	assign any_open = |bank_open;

	always_ff @(posedge CLK_n) begin
		if (!RST) begin
			bank_open      <= '0;
			protocol_error <= 1'b0;
		end else begin
			protocol_error <= 1'b0; // single-cycle pulse
			if (cke) begin
				case (cmd_pin)
					ACTV: begin
						if (hit_open)
							protocol_error <= 1'b1; // row already active
						bank_open[bank_pin] <= 1'b1;
					end
					READ, WRTE, BTRM: begin
						if (!hit_open)
							protocol_error <= 1'b1; // no open row
					end
					PRCH: begin
						if (addr_pin.row[10])
							bank_open <= '0; // precharge all
						else
							bank_open[bank_pin] <= 1'b0;
					end
					ARSR, MRST: begin
						// refresh and mode set need every bank idle
						if (any_open)
							protocol_error <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== design/ddr2_cmd_front.sv ====
`timescale 1ns/1ps
`include "ddr2_macros.svh"

module ddr2_cmd_front import ddr2_pkg::*; (
	input  logic                         CLK_n,
	input  logic                         RST,
	input  ddr2_cmd_e                    user_cmd,
	input  ddr2_addr_u                   user_addr,
	input  logic [`DDR2_BANK_W-1:0]      user_bank,
	output logic                         cke,
	output ddr2_cmd_e                    cmd_pin,
	output ddr2_addr_u                   addr_pin,
	output logic [`DDR2_BANK_W-1:0]      bank_pin,
	output logic                         user_ready,
	output logic [(1<<`DDR2_BANK_W)-1:0] bank_open,
	output logic                         protocol_error
);

	logic                     timer_load;
	logic [`DDR2_TIMER_W-1:0] timer_value;
	logic                     timer_done;
	logic [3:0]               step;
	ddr2_cmd_e                rom_cmd;
	ddr2_addr_u               rom_addr;
	logic [`DDR2_BANK_W-1:0]  rom_bank;

	ddr2_init_seq i_seq (
		.CLK_n       (CLK_n),
		.RST         (RST),
		.timer_done  (timer_done),
		.timer_load  (timer_load),
		.timer_value (timer_value),
		.step        (step),
		.rom_cmd     (rom_cmd),
		.rom_addr    (rom_addr),
		.rom_bank    (rom_bank),
		.user_cmd    (user_cmd),
		.user_addr   (user_addr),
		.user_bank   (user_bank),
		.cke         (cke),
		.cmd_pin     (cmd_pin),
		.addr_pin    (addr_pin),
		.bank_pin    (bank_pin),
		.user_ready  (user_ready)
	);

	ddr2_init_rom i_rom (
		.step     (step),
		.rom_cmd  (rom_cmd),
		.rom_addr (rom_addr),
		.rom_bank (rom_bank)
	);

	ddr2_wait_timer i_timer (
		.CLK_n       (CLK_n),
		.RST         (RST),
		.timer_load  (timer_load),
		.timer_value (timer_value),
		.timer_done  (timer_done)
	);

	// watches the pins, init traffic included
	ddr2_bank_tracker i_tracker (
		.CLK_n          (CLK_n),
		.RST            (RST),
		.cke            (cke),
		.cmd_pin        (cmd_pin),
		.addr_pin       (addr_pin),
		.bank_pin       (bank_pin),
		.bank_open      (bank_open),
		.protocol_error (protocol_error)
	);

endmodule

// ==== design/ddr2_init_rom.sv ====
`timescale 1ns/1ps
`include "ddr2_macros.svh"

module ddr2_init_rom import ddr2_pkg::*; (
	input  logic [3:0]             step,
	output ddr2_cmd_e              rom_cmd,
	output ddr2_addr_u             rom_addr,
	output logic [`DDR2_BANK_W-1:0] rom_bank
);

	always_comb begin
		rom_cmd  = NOOP;
		rom_addr = '0;
		rom_bank = '0;
		case (step)
			4'd0, 4'd5: begin
				rom_cmd          = PRCH;
				rom_addr.row[10] = 1'b1; // all banks
			end
			4'd1: begin
				rom_cmd  = MRST; // EMR2, all zero
				rom_bank = 3'd2;
			end
			4'd2: begin
				rom_cmd  = MRST; // EMR3, all zero
				rom_bank = 3'd3;
			end
			4'd3, 4'd10: begin
				rom_cmd                   = MRST; // EMR, dll on, ocd exit
				rom_bank                  = 3'd1;
				rom_addr.mode.wr_recovery = 3'b010; // A10, dqs# disable
			end
			4'd4, 4'd8: begin
				rom_cmd                   = MRST; // MR
				rom_addr.mode.burst_len   = 3'b010; // BL4
				rom_addr.mode.burst_type  = 1'b0;
				rom_addr.mode.cas_lat     = 3'd3;
				rom_addr.mode.dll_reset   = (step == 4'd4); // only on the first MR
				rom_addr.mode.wr_recovery = 3'b010; // WR3
			end
			4'd6, 4'd7: begin
				rom_cmd = ARSR;
			end
			4'd9: begin
				// EMR with OCD default, A9..A7 all set, plus dqs# disable
				rom_cmd                   = MRST;
				rom_bank                  = 3'd1;
				rom_addr.mode.test_mode   = 1'b1; // A7
				rom_addr.mode.dll_reset   = 1'b1; // A8
				rom_addr.mode.wr_recovery = 3'b011; // A10, A9
			end
			default: begin
				rom_addr.row[10] = 1'b1;
			end
		endcase
	end

endmodule

// ==== design/ddr2_init_seq.sv ====
`timescale 1ns/1ps
`include "ddr2_macros.svh"

module ddr2_init_seq import ddr2_pkg::*; (
	input  logic                      CLK_n,
	input  logic                      RST,
	input  logic                      timer_done,
	output logic                      timer_load,
	output logic [`DDR2_TIMER_W-1:0]  timer_value,
	output logic [3:0]                step,
	input  ddr2_cmd_e                 rom_cmd,
	input  ddr2_addr_u                rom_addr,
	input  logic [`DDR2_BANK_W-1:0]   rom_bank,
	input  ddr2_cmd_e                 user_cmd,
	input  ddr2_addr_u                user_addr,
	input  logic [`DDR2_BANK_W-1:0]   user_bank,
	output logic                      cke,
	output ddr2_cmd_e                 cmd_pin,
	output ddr2_addr_u                addr_pin,
	output logic [`DDR2_BANK_W-1:0]   bank_pin,
	output logic                      user_ready
);

	localparam int unsigned TW = `DDR2_TIMER_W;
	localparam logic [3:0] LAST_STEP = 4'(`DDR2_INIT_STEPS - 1);

	typedef enum logic [1:0] {POWERUP, COMMANDS, HANDOFF, USER} state_e;

	state_e                  state;
	logic                    pwr_armed; // power-up wait loaded
	ddr2_cmd_e               cmd_q;
	ddr2_addr_u              addr_q;
	logic [`DDR2_BANK_W-1:0] bank_q;

	always_comb begin
		timer_load  = 1'b0;
		timer_value = TW'(`DDR2_CMD_GAP);
		case (state)
			POWERUP: begin
				if (!pwr_armed) begin
					timer_load  = 1'b1;
					timer_value = TW'(`DDR2_POWERUP_CYCLES);
				end else if (timer_done) begin
					timer_load = 1'b1; // gap up to the first command
				end
			end
			COMMANDS: begin
				timer_load = timer_done;
				if (step == LAST_STEP)
					timer_value = TW'(`DDR2_HANDOFF_CYCLES);
			end
			default: ; // handoff and user wait on the running count
		endcase
	end

	always_ff @(posedge CLK_n) begin
		if (!RST) begin
			state      <= POWERUP;
			pwr_armed  <= 1'b0;
			cke        <= 1'b0;
			user_ready <= 1'b0;
			step       <= '0;
			cmd_q      <= NOOP;
		end else begin
			cmd_q <= NOOP; // gap filler
			case (state)
				POWERUP: begin
					pwr_armed <= 1'b1;
					if (pwr_armed && timer_done) begin
						cke   <= 1'b1;
						state <= COMMANDS;
					end
				end
				COMMANDS: begin
					if (timer_done) begin
						cmd_q <= rom_cmd;
						step  <= step + 4'd1;
						if (step == LAST_STEP)
							state <= HANDOFF;
					end
				end
				HANDOFF: begin
					if (timer_done) begin
						user_ready <= 1'b1;
						state      <= USER;
					end
				end
				default: ; // user owns the pins
			endcase
		end
	end

	always_ff @(posedge CLK_n) begin
		if (state == COMMANDS && timer_done) begin
			addr_q <= rom_addr;
			bank_q <= rom_bank;
		end
	end

	// user path is combinational once handed off
	assign cmd_pin  = user_ready ? user_cmd  : cmd_q;
	assign addr_pin = user_ready ? user_addr : addr_q;
	assign bank_pin = user_ready ? user_bank : bank_q;

endmodule

// ==== design/ddr2_macros.svh ====
`ifndef DDR2_MACROS_SVH
`define DDR2_MACROS_SVH

// scaled-down wait lengths, in CLK_n cycles
`define DDR2_POWERUP_CYCLES 64 // cke held low after reset
`define DDR2_CMD_GAP 8 // issue to issue during init
`define DDR2_HANDOFF_CYCLES 32 // last init command to user_ready

// init table depth
`define DDR2_INIT_STEPS 11

// field widths
`define DDR2_ADDR_W 14
`define DDR2_BANK_W 3
`define DDR2_TIMER_W 8

`endif

// ==== design/ddr2_pkg.sv ====
`include "ddr2_macros.svh"

package ddr2_pkg;

	// RAS/CAS/WE as seen on the pins
	typedef enum logic [2:0] {
		MRST = 3'b000, // mode register set
		ARSR = 3'b001, // auto refresh
		PRCH = 3'b010, // precharge
		ACTV = 3'b011, // activate
		WRTE = 3'b100, // write
		READ = 3'b101, // read
		BTRM = 3'b110, // burst terminate
		NOOP = 3'b111
	} ddr2_cmd_e;

	// mode register layout, A13 down to A0
	typedef struct packed {
		logic       upper; // A13, unused
		logic       pd_exit; // A12
		logic [2:0] wr_recovery; // A11..A9
		logic       dll_reset; // A8
		logic       test_mode; // A7
		logic [2:0] cas_lat; // A6..A4
		logic       burst_type; // A3, 0 = sequential
		logic [2:0] burst_len; // A2..A0
	} ddr2_mode_t;

	// one address word, read either as a row or as a mode word
	typedef union packed {
		logic [`DDR2_ADDR_W-1:0] row; // row number, A10 = all banks on PRCH
		ddr2_mode_t              mode;
	} ddr2_addr_u;

endpackage

// ==== design/ddr2_wait_timer.sv ====
`timescale 1ns/1ps
`include "ddr2_macros.svh"

module ddr2_wait_timer (
	input  logic                     CLK_n,
	input  logic                     RST,
	input  logic                     timer_load,
	input  logic [`DDR2_TIMER_W-1:0] timer_value,
	output logic                     timer_done
);

	logic [`DDR2_TIMER_W-1:0] count;

	// load counts the load cycle itself
	always_ff @(posedge CLK_n) begin
		if (!RST) begin
			count <= '0;
		end else if (timer_load) begin
			count <= timer_value - `DDR2_TIMER_W'(1);
		end else if (count != '0) begin
			count <= count - `DDR2_TIMER_W'(1); // park at zero
		end
	end

	assign timer_done = (count == '0);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run with Verilator, verdict taken from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module ddr2_cmd_front_tb \
	-f ddr2_cmd_front.f -o ddr2_cmd_front_sim \
	&& ./obj_dir/ddr2_cmd_front_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "STATUS: FAIL" sim.log && echo "simulation failed" && exit 1
grep -q "STATUS: PASS" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

// ==== verification/ddr2_cmd_front_patterns.txt ====
// columns: cmd addr bank exp_bank_open exp_protocol_error, all hex
// cmd codes: 0 MRST 1 ARSR 2 PRCH 3 ACTV 4 WRTE 5 READ 6 BTRM 7 NOOP
// init sequence, in issue order
2 0400 0 00 0
0 0000 2 00 0
0 0000 3 00 0
0 0400 1 00 0
0 0532 0 00 0
2 0400 0 00 0
1 0000 0 00 0
1 0000 0 00 0
0 0432 0 00 0
0 0780 1 00 0
0 0400 1 00 0
// user commands
3 0123 0 01 0
3 0456 3 09 0
5 0000 0 09 0
4 0000 3 09 0
5 0000 5 09 1
3 0789 3 09 1
2 0000 0 08 0
1 0000 0 08 1
2 0400 2 00 0
1 0000 0 00 0

// ==== verification/ddr2_cmd_front_props.sv ====
`timescale 1ns/1ps
`include "ddr2_macros.svh"

module ddr2_cmd_front_props import ddr2_pkg::*; (
	input logic      CLK_n,
	input logic      RST,
	input logic      cke,
	input ddr2_cmd_e cmd_pin,
	input logic      user_ready,
	input logic      protocol_error
);

	logic [7:0] since_cmd; // cycles since the last real command

	always_ff @(posedge CLK_n) begin
		if (!RST) begin
			since_cmd <= 8'hff;
		end else if (cmd_pin != NOOP) begin
			since_cmd <= '0;
		end else if (since_cmd != 8'hff) begin
			since_cmd <= since_cmd + 8'd1; // saturates
		end
	end

	a_noop_cke_low: assert property (@(posedge CLK_n) disable iff (!RST)
		!cke |-> cmd_pin == NOOP)
		else $error("command issued while cke is low");

	a_ready_sticky: assert property (@(posedge CLK_n) disable iff (!RST)
		user_ready |=> user_ready)
		else $error("user_ready fell after hand-off");

	a_init_gap: assert property (@(posedge CLK_n) disable iff (!RST)
		(!user_ready && cmd_pin != NOOP) |-> since_cmd >= 8'(`DDR2_CMD_GAP - 1))
		else $error("init commands closer than the command gap");

	a_no_early_error: assert property (@(posedge CLK_n) disable iff (!RST)
		!user_ready |-> !protocol_error)
		else $error("protocol_error during initialization");

endmodule

// ==== verification/ddr2_cmd_front_tb.sv ====
`timescale 1ns/1ps
`include "ddr2_macros.svh"

module ddr2_cmd_front_tb import ddr2_pkg::*; ();

	localparam int N_INIT = `DDR2_INIT_STEPS;
	localparam int N_USER = 10;
	localparam int N_WORDS = 5 * (N_INIT + N_USER);
	localparam int LIMIT = `DDR2_POWERUP_CYCLES + 12 * `DDR2_CMD_GAP
		+ `DDR2_HANDOFF_CYCLES + 4 * N_USER + 50;

	logic                         CLK_n;
	logic                         RST;
	ddr2_cmd_e                    user_cmd;
	ddr2_addr_u                   user_addr;
	logic [`DDR2_BANK_W-1:0]      user_bank;
	logic                         cke;
	ddr2_cmd_e                    cmd_pin;
	ddr2_addr_u                   addr_pin;
	logic [`DDR2_BANK_W-1:0]      bank_pin;
	logic                         user_ready;
	logic [(1<<`DDR2_BANK_W)-1:0] bank_open;
	logic                         protocol_error;

	logic [15:0] pat [0:N_WORDS-1]; // five words per entry
	logic [7:0]  lfsr;
	int          cyc = 0;
	int          value_errs = 0;
	int          timing_errs = 0;

	ddr2_cmd_front i_dut (
		.CLK_n          (CLK_n),
		.RST            (RST),
		.user_cmd       (user_cmd),
		.user_addr      (user_addr),
		.user_bank      (user_bank),
		.cke            (cke),
		.cmd_pin        (cmd_pin),
		.addr_pin       (addr_pin),
		.bank_pin       (bank_pin),
		.user_ready     (user_ready),
		.bank_open      (bank_open),
		.protocol_error (protocol_error)
	);

	bind ddr2_cmd_front ddr2_cmd_front_props i_props (
		.CLK_n          (CLK_n),
		.RST            (RST),
		.cke            (cke),
		.cmd_pin        (cmd_pin),
		.user_ready     (user_ready),
		.protocol_error (protocol_error)
	);

	always #5 CLK_n = ~CLK_n;

	always @(posedge CLK_n) begin
		cyc <= cyc + 1;
		if (cyc > LIMIT) begin
			$display("timeout: run passed %0d cycles without finishing", LIMIT);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// taps 8,6,5,4
	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	function automatic ddr2_cmd_e cmd_of(input int k);
		return ddr2_cmd_e'(pat[5 * k][2:0]);
	endfunction

	function automatic ddr2_addr_u addr_of(input int k);
		ddr2_addr_u a;
		a.row = pat[5 * k + 1][`DDR2_ADDR_W-1:0];
		return a;
	endfunction

	function automatic logic [`DDR2_BANK_W-1:0] bank_of(input int k);
		return pat[5 * k + 2][`DDR2_BANK_W-1:0];
	endfunction

	task automatic check_cmd(input string name, input ddr2_cmd_e got, input ddr2_cmd_e exp);
		if (got !== exp) begin
			value_errs++;
			$display("error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input ddr2_addr_u got, input ddr2_addr_u exp);
		if (got !== exp) begin
			value_errs++;
			$display("error %s: got %h, expected %h", name, got.row, exp.row);
		end
	endtask

	task automatic check_bank(input string name, input logic [`DDR2_BANK_W-1:0] got,
		input logic [`DDR2_BANK_W-1:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errs++;
			$display("error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_flags(input logic [7:0] got_open, input logic got_err,
		input logic [7:0] exp_open, input logic exp_err);
		if (got_open !== exp_open) begin
			value_errs++;
			$display("error bank_open: got %h, expected %h", got_open, exp_open);
		end
		if (got_err !== exp_err) begin
			value_errs++;
			$display("error protocol_error: got %h, expected %h", got_err, exp_err);
		end
	endtask

	task automatic compare_interval(input string what, input int got, input int exp);
		if (got != exp) begin
			timing_errs++;
			$display("%s took %0d cycles instead of %0d", what, got, exp);
		end
	endtask

	initial begin
		int         last;
		logic [1:0] idle;
		CLK_n = 1'b0;
		RST <= 1'b0;
		user_cmd <= NOOP;
		user_addr <= '0;
		user_bank <= '0;
		lfsr = 8'd11;
		$readmemh("verification/ddr2_cmd_front_patterns.txt", pat);

		repeat (2) @(posedge CLK_n);
		RST <= 1'b1;
		@(negedge CLK_n);
		check_level("cke", cke, 1'b0);
		check_level("user_ready", user_ready, 1'b0);
		check_cmd("cmd_pin", cmd_pin, NOOP);
		check_flags(bank_open, protocol_error, 8'h00, 1'b0);
		last = cyc + 1; // first edge with RST high
		while (!cke) @(negedge CLK_n);
		compare_interval("power-up wait", cyc - last, `DDR2_POWERUP_CYCLES);
		last = cyc;

		for (int i = 0; i < N_INIT; i++) begin
			while (cmd_pin == NOOP) @(negedge CLK_n);
			compare_interval("init command gap", cyc - last, `DDR2_CMD_GAP);
			last = cyc;
			check_cmd("cmd_pin", cmd_pin, cmd_of(i));
			check_addr("addr_pin", addr_pin, addr_of(i));
			check_bank("bank_pin", bank_pin, bank_of(i));
			@(negedge CLK_n);
			check_flags(bank_open, protocol_error, pat[5 * i + 3][7:0], pat[5 * i + 4][0]);
		end

		while (!user_ready) @(negedge CLK_n);
		compare_interval("hand-off wait", cyc - last, `DDR2_HANDOFF_CYCLES);

		for (int k = N_INIT; k < N_INIT + N_USER; k++) begin
			for (int b = 0; b < 2; b++) begin
				lfsr = lfsr_step(lfsr);
				idle[b] = lfsr[0];
			end
			repeat (idle) @(posedge CLK_n); // idle NOOP cycles
			@(posedge CLK_n);
			user_cmd <= cmd_of(k);
			user_addr <= addr_of(k);
			user_bank <= bank_of(k);
			@(negedge CLK_n);
			check_cmd("cmd_pin", cmd_pin, cmd_of(k)); // same-cycle pass-through
			check_addr("addr_pin", addr_pin, addr_of(k));
			check_bank("bank_pin", bank_pin, bank_of(k));
			@(posedge CLK_n);
			user_cmd <= NOOP;
			@(negedge CLK_n);
			check_flags(bank_open, protocol_error, pat[5 * k + 3][7:0], pat[5 * k + 4][0]);
		end

		@(negedge CLK_n);
		$display("done: %0d value errors, %0d timing errors", value_errs, timing_errs);
		if (value_errs + timing_errs == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule
